// ==== src/mem_pkg.sv ====
package mem_pkg;

    // Word geometry
    localparam int WORD_BITS     = 32;
    localparam int WORD_BYTES    = 4;
    localparam int RAM_WORDS     = 1024;
    localparam int RAM_ADDR_BITS = 10;
    // Words decoded into the I/O block, only two are backed by registers
    localparam int IO_WORDS      = 16;

    typedef logic [WORD_BITS-1:0]     word_t;
    typedef logic [31:0]              addr_t;
    typedef logic [WORD_BITS-1:0]     mask_t;
    typedef logic [2*WORD_BITS-1:0]   dword_t;
    typedef logic [RAM_ADDR_BITS-1:0] ram_idx_t;

    // Memory map, byte addresses
    localparam addr_t RAM_BYTES     = addr_t'(RAM_WORDS * WORD_BYTES);
    localparam addr_t IO_BASE       = 32'h0001_0000;
    localparam addr_t IO_BYTES      = addr_t'(IO_WORDS * WORD_BYTES);
    // Byte offsets inside the I/O region
    localparam addr_t GPIO_OFFSET   = 32'h0000_0000;
    localparam addr_t CNT_OFFSET    = 32'h0000_0004;
    localparam word_t UNMAPPED_DATA = '1;
    localparam mask_t FULL_MASK     = '1;

    // Byte-addressed request from the processor port
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
        mask_t wmask;
    } access_req_t;

    // Word-aligned command toward the memory map and its parts
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
    } word_cmd_t;

    typedef enum logic [3:0] {
        IDLE,
        FIRST_CMD,
        RMW_READ1,
        READ2_CMD,
        RMW_READ2,
        WRITE1_CMD,
        WRITE2_CMD,
        READ1_WAIT,
        READ2_WAIT,
        DONE
    } access_state_e;

endpackage

// ==== src/word_ram.sv ====
`timescale 1ns/1ps

module word_ram (
    input  logic               clk,
    input  mem_pkg::word_cmd_t cmd,
    input  logic               sel,
    output mem_pkg::word_t     rdata
);

    // Word storage
    mem_pkg::word_t mem [mem_pkg::RAM_WORDS];

    mem_pkg::ram_idx_t idx;

    // Word index sits above the byte offset
    assign idx = cmd.addr[mem_pkg::RAM_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (sel) begin
            if (cmd.write) begin
                mem[idx] <= cmd.wdata;
            end else begin
                // Read data shows one cycle later
                rdata <= mem[idx];
            end
        end
    end

endmodule

// ==== src/io_regs.sv ====
`timescale 1ns/1ps

module io_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  mem_pkg::word_cmd_t cmd,
    input  logic               sel,
    output mem_pkg::word_t     rdata,
    output mem_pkg::word_t     gpio
);

    mem_pkg::addr_t offset;
    mem_pkg::word_t cycle_cnt;

    // Offset inside the I/O region
    assign offset = cmd.addr - mem_pkg::IO_BASE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
            gpio      <= '0;
        end else begin
            // Free running, writes to it are dropped
            cycle_cnt <= cycle_cnt + 1'b1;
            if (sel && cmd.write && offset == mem_pkg::GPIO_OFFSET) begin
                gpio <= cmd.wdata;
            end
        end
    end

    // Registered read mux
    always_ff @(posedge clk) begin
        if (sel && !cmd.write) begin
            case (offset)
                mem_pkg::GPIO_OFFSET: rdata <= gpio;
                mem_pkg::CNT_OFFSET:  rdata <= cycle_cnt;
                default:              rdata <= mem_pkg::UNMAPPED_DATA;
            endcase
        end
    end

endmodule

// ==== src/mem_map_ctrl.sv ====
`timescale 1ns/1ps

module mem_map_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  mem_pkg::word_cmd_t cmd,
    input  logic               start,
    output logic               ready,
    output mem_pkg::word_t     rdata,
    output logic               rdata_valid,
    output mem_pkg::word_t     gpio
);

    logic           ram_sel;
    logic           io_sel;
    mem_pkg::word_t ram_rdata;
    mem_pkg::word_t io_rdata;
    logic           in_ram;
    logic           in_io;
    logic           accept;
    // Target of the read in flight
    logic           rd_ram;
    logic           rd_io;

    // Address decode
    assign in_ram = (cmd.addr < mem_pkg::RAM_BYTES);
    assign in_io  = (cmd.addr >= mem_pkg::IO_BASE) &&
                    (cmd.addr < mem_pkg::IO_BASE + mem_pkg::IO_BYTES);

    // Busy only in the cycle that returns read data
    assign ready   = !rdata_valid;
    assign accept  = start && ready;
    assign ram_sel = accept && in_ram;
    assign io_sel  = accept && in_io;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid <= 1'b0;
            rd_ram      <= 1'b0;
            rd_io       <= 1'b0;
        end else begin
            // Unmapped reads still answer, with neither flag set
            rdata_valid <= accept && !cmd.write;
            rd_ram      <= ram_sel && !cmd.write;
            rd_io       <= io_sel && !cmd.write;
        end
    end

    // Return path
    assign rdata = rd_ram ? ram_rdata :
                   rd_io  ? io_rdata  : mem_pkg::UNMAPPED_DATA;

    word_ram u_ram (
        .clk   (clk),
        .cmd   (cmd),
        .sel   (ram_sel),
        .rdata (ram_rdata)
    );

    io_regs u_io (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd),
        .sel   (io_sel),
        .rdata (io_rdata),
        .gpio  (gpio)
    );

    // Regions must not overlap
    a_one_part: assert property (@(posedge clk) disable iff (!rst_n)
        !(ram_sel && io_sel));

endmodule

// ==== src/mem_access_ctrl.sv ====
`timescale 1ns/1ps

module mem_access_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_start,
    input  mem_pkg::access_req_t req,
    output logic                 cmd_ready,
    output mem_pkg::word_t       rdata,
    output logic                 rdata_valid,
    output mem_pkg::word_cmd_t   mem_cmd,
    output logic                 mem_start,
    input  logic                 mem_ready,
    input  mem_pkg::word_t       mem_rdata,
    input  logic                 mem_rdata_valid
);

    mem_pkg::access_state_e state;
    mem_pkg::access_req_t   save;
    mem_pkg::word_t         rdata1;
    mem_pkg::word_t         rdata2;
    mem_pkg::addr_t         base_addr;
    logic [1:0]             byte_off;
    logic [4:0]             shift_bits;
    logic                   aligned;
    logic                   full_write;
    logic                   mem_accept;
    mem_pkg::dword_t        data_win;
    mem_pkg::dword_t        mask_win;
    mem_pkg::dword_t        read_win;
    mem_pkg::word_t         splice;
    mem_pkg::word_t         wword1;
    mem_pkg::word_t         wword2;

    // Keep old bits where the mask is clear
    function automatic mem_pkg::word_t merge_word(
        input mem_pkg::word_t old_word,
        input mem_pkg::word_t new_word,
        input mem_pkg::mask_t mask
    );
        merge_word = (old_word & ~mask) | (new_word & mask);
    endfunction

    assign base_addr  = {save.addr[31:2], 2'b00};
    assign byte_off   = save.addr[1:0];
    assign shift_bits = {byte_off, 3'b000};
    assign aligned    = (byte_off == 2'd0);
    // Only this case skips the read-modify-write
    assign full_write = save.write && aligned && (save.wmask == mem_pkg::FULL_MASK);
    assign mem_accept = mem_start && mem_ready;
    assign cmd_ready  = (state == mem_pkg::IDLE);

    // Data and mask moved up to the byte address, spanning two words
    assign data_win = mem_pkg::dword_t'(save.wdata) << shift_bits;
    assign mask_win = mem_pkg::dword_t'(save.wmask) << shift_bits;

    // Second word above the first, little-endian
    assign read_win = {mem_rdata, rdata1} >> shift_bits;
    assign splice   = read_win[31:0];

    // With a full mask the first merge gives wdata itself
    assign wword1 = merge_word(rdata1, data_win[31:0], mask_win[31:0]);
    assign wword2 = merge_word(rdata2, data_win[63:32], mask_win[63:32]);

    // Word command for the current step
    always_comb begin
        mem_start     = 1'b0;
        mem_cmd.write = 1'b0;
        mem_cmd.addr  = base_addr;
        mem_cmd.wdata = wword1;
        case (state)
            mem_pkg::FIRST_CMD: begin
                mem_start     = 1'b1;
                mem_cmd.write = full_write;
            end
            mem_pkg::READ2_CMD: begin
                mem_start    = 1'b1;
                mem_cmd.addr = base_addr + mem_pkg::addr_t'(mem_pkg::WORD_BYTES);
            end
            mem_pkg::WRITE1_CMD: begin
                mem_start     = 1'b1;
                mem_cmd.write = 1'b1;
            end
            mem_pkg::WRITE2_CMD: begin
                mem_start     = 1'b1;
                mem_cmd.write = 1'b1;
                mem_cmd.addr  = base_addr + mem_pkg::addr_t'(mem_pkg::WORD_BYTES);
                mem_cmd.wdata = wword2;
            end
            default: begin
                mem_start = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= mem_pkg::IDLE;
            rdata_valid <= 1'b0;
        end else begin
            // Single-cycle pulse
            rdata_valid <= 1'b0;
            case (state)
                mem_pkg::IDLE: begin
                    if (cmd_start) begin
                        state <= mem_pkg::FIRST_CMD;
                    end
                end
                mem_pkg::FIRST_CMD: begin
                    if (mem_accept) begin
                        if (!save.write) begin
                            state <= mem_pkg::READ1_WAIT;
                        end else if (full_write) begin
                            state <= mem_pkg::DONE;
                        end else begin
                            state <= mem_pkg::RMW_READ1;
                        end
                    end
                end
                mem_pkg::RMW_READ1: begin
                    if (mem_rdata_valid) begin
                        state <= aligned ? mem_pkg::WRITE1_CMD : mem_pkg::READ2_CMD;
                    end
                end
                mem_pkg::READ2_CMD: begin
                    if (mem_accept) begin
                        state <= save.write ? mem_pkg::RMW_READ2 : mem_pkg::READ2_WAIT;
                    end
                end
                mem_pkg::RMW_READ2: begin
                    if (mem_rdata_valid) begin
                        state <= mem_pkg::WRITE1_CMD;
                    end
                end
                mem_pkg::WRITE1_CMD: begin
                    if (mem_accept) begin
                        state <= aligned ? mem_pkg::DONE : mem_pkg::WRITE2_CMD;
                    end
                end
                mem_pkg::WRITE2_CMD: begin
                    if (mem_accept) begin
                        state <= mem_pkg::DONE;
                    end
                end
                // Wait states hold one more cycle while rdata_valid is out
                mem_pkg::READ1_WAIT: begin
                    if (rdata_valid) begin
                        state <= mem_pkg::IDLE;
                    end else if (mem_rdata_valid) begin
                        if (aligned) begin
                            rdata_valid <= 1'b1;
                        end else begin
                            state <= mem_pkg::READ2_CMD;
                        end
                    end
                end
                mem_pkg::READ2_WAIT: begin
                    if (rdata_valid) begin
                        state <= mem_pkg::IDLE;
                    end else if (mem_rdata_valid) begin
                        rdata_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= mem_pkg::IDLE;
                end
            endcase
        end
    end

    // Request and word buffers
    always_ff @(posedge clk) begin
        if (cmd_start && cmd_ready) begin
            save <= req;
        end
        if ((state == mem_pkg::RMW_READ1 || state == mem_pkg::READ1_WAIT) && mem_rdata_valid) begin
            rdata1 <= mem_rdata;
        end
        if (state == mem_pkg::RMW_READ2 && mem_rdata_valid) begin
            rdata2 <= mem_rdata;
        end
        if (state == mem_pkg::READ1_WAIT && mem_rdata_valid) begin
            rdata <= mem_rdata;
        end
        if (state == mem_pkg::READ2_WAIT && mem_rdata_valid) begin
            rdata <= splice;
        end
    end

    // Read result only leaves from a read wait state
    a_rvalid_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |-> (state == mem_pkg::READ1_WAIT || state == mem_pkg::READ2_WAIT));

    // Map is never busy when a step issues its command
    a_start_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
        mem_start |-> mem_ready);

endmodule

// ==== src/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_start,
    input  mem_pkg::access_req_t req,
    output logic                 cmd_ready,
    output mem_pkg::word_t       rdata,
    output logic                 rdata_valid,
    output mem_pkg::word_t       gpio
);

    // Controller to map link
    mem_pkg::word_cmd_t mem_cmd;
    logic               mem_start;
    logic               mem_ready;
    mem_pkg::word_t     mem_rdata;
    logic               mem_rdata_valid;

    mem_access_ctrl u_access (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_start       (cmd_start),
        .req             (req),
        .cmd_ready       (cmd_ready),
        .rdata           (rdata),
        .rdata_valid     (rdata_valid),
        .mem_cmd         (mem_cmd),
        .mem_start       (mem_start),
        .mem_ready       (mem_ready),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid)
    );

    mem_map_ctrl u_map (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (mem_cmd),
        .start       (mem_start),
        .ready       (mem_ready),
        .rdata       (mem_rdata),
        .rdata_valid (mem_rdata_valid),
        .gpio        (gpio)
    );

endmodule

// ==== tb/tb_mem_subsys_top.sv ====
`timescale 1ns/1ps

module tb_mem_subsys_top;

    localparam int TIMEOUT   = 50;
    // RAM words preloaded through the port, later tests stay inside
    localparam int WIN_WORDS = 64;

    logic                 clk;
    logic                 rst_n;
    logic                 cmd_start;
    mem_pkg::access_req_t req;
    logic                 cmd_ready;
    mem_pkg::word_t       rdata;
    logic                 rdata_valid;
    mem_pkg::word_t       gpio;

    // Byte image of the RAM region
    logic [7:0]     ref_mem [mem_pkg::RAM_WORDS*mem_pkg::WORD_BYTES];
    mem_pkg::word_t exp_rdata;
    mem_pkg::word_t got_rdata;
    mem_pkg::word_t gpio_ref;
    mem_pkg::word_t cnt_a;
    mem_pkg::word_t cnt_b;
    logic           read_busy;
    logic           check_data;
    logic [31:0]    seed;
    int             errors;
    int             accesses;

    mem_subsys_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_start   (cmd_start),
        .req         (req),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .gpio        (gpio)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Byte j of the word comes from address + j
    function automatic mem_pkg::word_t model_read(input mem_pkg::addr_t addr);
        mem_pkg::word_t w;
        int             j;
        for (j = 0; j < 4; j++) begin
            w[8*j +: 8] = ref_mem[addr + j];
        end
        return w;
    endfunction

    // Mask bit i guards data bit i, placed from the byte address upward
    task automatic model_write(input mem_pkg::addr_t addr, input mem_pkg::word_t wdata,
                               input mem_pkg::mask_t wmask);
        int i;
        for (i = 0; i < 32; i++) begin
            if (wmask[i]) begin
                ref_mem[addr + i/8][i%8] = wdata[i];
            end
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT);
        $display("Run aborted: %0d accesses, %0d errors", accesses, errors);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    // One request on the port, returns once cmd_ready is back
    task automatic run_access(input logic wr, input mem_pkg::addr_t addr,
                              input mem_pkg::word_t wdata, input mem_pkg::mask_t wmask);
        int waited;
        waited = 0;
        while (!cmd_ready) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_timeout("cmd_ready before the request");
            end
        end
        req       = '{write: wr, addr: addr, wdata: wdata, wmask: wmask};
        cmd_start = 1'b1;
        read_busy = !wr;
        accesses++;
        @(negedge clk);
        cmd_start = 1'b0;
        waited    = 0;
        while (!wr && !rdata_valid) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_timeout("rdata_valid for a read");
            end
        end
        got_rdata = rdata;
        waited    = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_timeout("cmd_ready after the access");
            end
        end while (!cmd_ready);
        read_busy = 1'b0;
    endtask

    // Reads carry a full mask, which the port must ignore
    task automatic read_expect(input mem_pkg::addr_t addr, input mem_pkg::word_t expected,
                               input logic check);
        exp_rdata  = expected;
        check_data = check;
        run_access(1'b0, addr, '0, mem_pkg::FULL_MASK);
    endtask

    task automatic read_ram(input mem_pkg::addr_t addr);
        read_expect(addr, model_read(addr), 1'b1);
    endtask

    task automatic write_ram(input mem_pkg::addr_t addr, input mem_pkg::word_t wdata,
                             input mem_pkg::mask_t wmask);
        model_write(addr, wdata, wmask);
        run_access(1'b1, addr, wdata, wmask);
    endtask

    // Read word against the expected value
    a_rdata_match: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid && check_data |-> rdata == exp_rdata)
    else begin
        errors++;
        $display("** Error @%0t: rdata %h, expected %h", $time, $sampled(rdata),
                 $sampled(exp_rdata));
    end

    a_no_stray_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |-> read_busy)
    else begin
        errors++;
        $display("At %0t rdata_valid pulsed with no read in progress", $time);
    end

    // Port idle right after the data pulse
    a_ready_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |=> cmd_ready)
    else begin
        errors++;
        $display("At %0t cmd_ready stayed low after rdata_valid", $time);
    end

    initial begin
        int             i;
        int             off;
        mem_pkg::addr_t a;
        mem_pkg::word_t d;
        mem_pkg::mask_t m;
        seed       = 32'hd17e;
        errors     = 0;
        accesses   = 0;
        rst_n      = 1'b0;
        cmd_start  = 1'b0;
        req        = '0;
        read_busy  = 1'b0;
        check_data = 1'b0;
        exp_rdata  = '0;
        gpio_ref   = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        a_reset_state: assert (cmd_ready && !rdata_valid && gpio == '0)
        else begin
            errors++;
            $display("** Error @%0t: port outputs not at reset values", $time);
        end
        // Gap between RAM and I/O, then an unbacked I/O word
        read_expect(32'h0000_8000, mem_pkg::UNMAPPED_DATA, 1'b1);
        read_expect(mem_pkg::IO_BASE + 32'h20, mem_pkg::UNMAPPED_DATA, 1'b1);
        for (i = 0; i < WIN_WORDS; i++) begin
            write_ram(mem_pkg::addr_t'(i * 4), next_rand(), mem_pkg::FULL_MASK);
        end
        // Full aligned words anywhere in RAM
        for (i = 0; i < 12; i++) begin
            a = mem_pkg::addr_t'((next_rand() % mem_pkg::RAM_WORDS) * 4);
            write_ram(a, next_rand(), mem_pkg::FULL_MASK);
            read_ram(a);
        end
        // Partial mask, aligned
        for (i = 0; i < 6; i++) begin
            a = mem_pkg::addr_t'((next_rand() % WIN_WORDS) * 4);
            d = next_rand();
            m = next_rand();
            write_ram(a, d, m);
            read_ram(a);
        end
        for (off = 1; off < 4; off++) begin
            for (i = 0; i < 3; i++) begin
                a = mem_pkg::addr_t'((next_rand() % (WIN_WORDS - 1)) * 4 + off);
                read_ram(a);
            end
        end
        // Unaligned masked writes touch two words
        for (off = 1; off < 4; off++) begin
            for (i = 0; i < 3; i++) begin
                a = mem_pkg::addr_t'((next_rand() % (WIN_WORDS - 1)) * 4 + off);
                d = next_rand();
                m = next_rand();
                write_ram(a, d, m);
                read_ram({a[31:2], 2'b00});
                read_ram({a[31:2], 2'b00} + 32'd4);
                read_ram(a);
            end
        end
        for (i = 0; i < 2; i++) begin
            d        = next_rand();
            m        = next_rand();
            gpio_ref = (gpio_ref & ~m) | (d & m);
            run_access(1'b1, mem_pkg::IO_BASE + mem_pkg::GPIO_OFFSET, d, m);
            a_gpio_value: assert (gpio == gpio_ref)
            else begin
                errors++;
                $display("** Error @%0t: gpio %h, expected %h", $time, gpio, gpio_ref);
            end
            read_expect(mem_pkg::IO_BASE + mem_pkg::GPIO_OFFSET, gpio_ref, 1'b1);
        end
        // Counter values are only compared with each other
        read_expect(mem_pkg::IO_BASE + mem_pkg::CNT_OFFSET, '0, 1'b0);
        cnt_a = got_rdata;
        read_expect(mem_pkg::IO_BASE + mem_pkg::CNT_OFFSET, '0, 1'b0);
        cnt_b = got_rdata;
        a_cnt_rises: assert (cnt_b > cnt_a)
        else begin
            errors++;
            $display("** Error @%0t: counter %h not above %h", $time, cnt_b, cnt_a);
        end
        run_access(1'b1, mem_pkg::IO_BASE + mem_pkg::CNT_OFFSET, '0, mem_pkg::FULL_MASK);
        read_expect(mem_pkg::IO_BASE + mem_pkg::CNT_OFFSET, '0, 1'b0);
        cnt_a = got_rdata;
        a_cnt_after_write: assert (cnt_a > cnt_b)
        else begin
            errors++;
            $display("** Error @%0t: counter %h stalled after write", $time, cnt_a);
        end
        @(negedge clk);
        $display("Run complete: %0d accesses, %0d errors", accesses, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== mem_subsys_top.f ====
src/mem_pkg.sv
src/word_ram.sv
src/io_regs.sv
src/mem_map_ctrl.sv
src/mem_access_ctrl.sv
src/mem_subsys_top.sv
tb/tb_mem_subsys_top.sv
